// ==== design/bp_settings.svh ====
// Sizing of the branch predictor tables.
// BP_BHT_ENTRIES and BP_BTB_ENTRIES must be powers of two, and the
// index widths must be their log2. PCs are assumed word aligned.

`ifndef BP_SETTINGS_SVH
`define BP_SETTINGS_SVH

// pattern history table
`define BP_BHT_ENTRIES 256
`define BP_BHT_IDX_W   8

// branch target buffer
`define BP_BTB_ENTRIES 64
`define BP_BTB_IDX_W   6
`define BP_BTB_TAG_W   (32 - `BP_BTB_IDX_W - 2)   // pc bits above the index

// weakly not taken, written by the reset sweep
`define BP_CTR_INIT    2'd1

`endif

// ==== design/bp_pkg.sv ====
// Types shared by the branch predictor and its testbench.
// Addresses are 32-bit byte addresses of 4-byte instructions.

package bp_pkg;

    localparam int unsigned ADDR_W = 32;

    typedef logic [ADDR_W-1:0] addr_t;

    // msb of the counter is the predicted direction
    typedef enum logic [1:0] {
        CTR_STRONG_NT = 2'd0,
        CTR_WEAK_NT   = 2'd1,
        CTR_WEAK_T    = 2'd2,
        CTR_STRONG_T  = 2'd3
    } ctr_state_e;

    // answer to fetch, same cycle as fetch_pc
    typedef struct packed {
        logic  taken;
        addr_t next_pc;
    } prediction_t;

    // outcome from the resolving stage, one-cycle strobe on valid.
    // pred_taken and pred_target are what fetch was told for this pc
    typedef struct packed {
        logic  valid;
        addr_t pc;
        logic  taken;
        addr_t target;
        logic  pred_taken;
        addr_t pred_target;
    } resolve_t;

    // recovery request to fetch
    typedef struct packed {
        logic  valid;
        addr_t pc;
    } redirect_t;

endpackage

// ==== design/bht_table.sv ====
// Table of 2-bit saturating counters indexed by pc[BHT_IDX_W+1:2].
// After reset a sweep writes BP_CTR_INIT to one entry per cycle; until it
// ends, lookups return not taken and updates are dropped.
// init_done rises BP_BHT_ENTRIES cycles after rst_i falls.

`timescale 1ns/1ps
`include "bp_settings.svh"

module bht_table (
    input  logic          clk,
    input  logic          rst_i,
    input  bp_pkg::addr_t lookup_pc,
    input  logic          update_valid,
    input  bp_pkg::addr_t update_pc,
    input  logic          update_taken,
    output logic          predict_taken,
    output logic          init_done
);
    import bp_pkg::*;

    localparam int unsigned ENTRIES = `BP_BHT_ENTRIES;
    localparam int unsigned IDX_W   = `BP_BHT_IDX_W;

    ctr_state_e       ctr_q [ENTRIES];
    logic [IDX_W-1:0] sweep_idx_q;
    logic             init_done_q;

    logic [IDX_W-1:0] lookup_idx;
    logic [IDX_W-1:0] update_idx;
    ctr_state_e       lookup_ctr;
    ctr_state_e       update_ctr;

    // saturating step toward the resolved direction
    function automatic ctr_state_e train(input ctr_state_e cur, input logic taken);
        ctr_state_e nxt;
        nxt = cur;
        case (cur)
            CTR_STRONG_NT: begin
                nxt = taken ? CTR_WEAK_NT : CTR_STRONG_NT;
            end
            CTR_WEAK_NT: begin
                nxt = taken ? CTR_WEAK_T : CTR_STRONG_NT;
            end
            CTR_WEAK_T: begin
                nxt = taken ? CTR_STRONG_T : CTR_WEAK_NT;
            end
            CTR_STRONG_T: begin
                nxt = taken ? CTR_STRONG_T : CTR_WEAK_T;
            end
            default: begin
                nxt = ctr_state_e'(`BP_CTR_INIT);
            end
        endcase
        return nxt;
    endfunction

    assign lookup_idx = lookup_pc[IDX_W+1:2];
    assign update_idx = update_pc[IDX_W+1:2];

    assign lookup_ctr = ctr_q[lookup_idx];
    assign update_ctr = train(ctr_q[update_idx], update_taken);

    // direction is the counter msb and stays low while sweeping
    assign predict_taken = init_done_q & lookup_ctr[1];
    assign init_done     = init_done_q;

    // sweep steps one entry per cycle after reset
    always_ff @(posedge clk) begin
        if (rst_i) begin
            sweep_idx_q <= '0;
            init_done_q <= 1'b0;
        end else if (!init_done_q) begin
            sweep_idx_q <= sweep_idx_q + 1'b1;
            if (sweep_idx_q == IDX_W'(ENTRIES - 1)) begin
                init_done_q <= 1'b1;   // last entry written this edge
            end
        end
    end

    // single write port shared by sweep and training
    always_ff @(posedge clk) begin
        if (!init_done_q) begin
            ctr_q[sweep_idx_q] <= ctr_state_e'(`BP_CTR_INIT);
        end else if (update_valid) begin
            ctr_q[update_idx] <= update_ctr;
        end
    end

endmodule

// ==== design/btb_table.sv ====
// Direct-mapped branch target buffer.
// Index is pc[BTB_IDX_W+1:2], tag is the pc bits above it.
// Only valid bits are reset; a write overwrites the entry unconditionally.

`timescale 1ns/1ps
`include "bp_settings.svh"

module btb_table (
    input  logic          clk,
    input  logic          rst_i,
    input  bp_pkg::addr_t lookup_pc,
    input  logic          write_en,
    input  bp_pkg::addr_t write_pc,
    input  bp_pkg::addr_t write_target,
    output logic          hit,
    output bp_pkg::addr_t target
);
    import bp_pkg::*;

    localparam int unsigned ENTRIES = `BP_BTB_ENTRIES;
    localparam int unsigned IDX_W   = `BP_BTB_IDX_W;
    localparam int unsigned TAG_W   = `BP_BTB_TAG_W;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        addr_t            target;
    } btb_entry_t;

    btb_entry_t       entry_q [ENTRIES];
    logic [ENTRIES-1:0] valid_q;

    logic [IDX_W-1:0] lookup_idx;
    logic [IDX_W-1:0] write_idx;
    logic [TAG_W-1:0] lookup_tag;
    logic [TAG_W-1:0] write_tag;
    btb_entry_t       lookup_entry;

    assign lookup_idx = lookup_pc[IDX_W+1:2];
    assign lookup_tag = lookup_pc[IDX_W+2 +: TAG_W];
    assign write_idx  = write_pc[IDX_W+1:2];
    assign write_tag  = write_pc[IDX_W+2 +: TAG_W];

    assign lookup_entry = entry_q[lookup_idx];

    assign hit    = valid_q[lookup_idx] && (lookup_entry.tag == lookup_tag);
    assign target = lookup_entry.target;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= '0;   // all entries dropped in one cycle
        end else if (write_en) begin
            valid_q[write_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write_en) begin
            entry_q[write_idx] <= '{tag: write_tag, target: write_target};
        end
    end

endmodule

// ==== design/resolve_unit.sv ====
// Checks each resolved branch against the prediction it carried and
// raises redirect one cycle later, for one cycle, on a mispredict.
// A wrong target on a correctly predicted taken branch also redirects.

`timescale 1ns/1ps

module resolve_unit (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              enable,
    input  bp_pkg::resolve_t  resolve,
    output bp_pkg::redirect_t redirect
);
    import bp_pkg::*;

    redirect_t redirect_q;

    logic  dir_wrong;
    logic  target_wrong;
    logic  mispredict;
    addr_t recovery_pc;

    assign dir_wrong    = resolve.taken != resolve.pred_taken;
    assign target_wrong = resolve.taken && (resolve.target != resolve.pred_target);
    assign mispredict   = dir_wrong || target_wrong;

    // taken goes to target, not taken falls through
    assign recovery_pc = resolve.taken ? resolve.target : resolve.pc + addr_t'(4);

    always_ff @(posedge clk) begin
        if (resolve.valid) begin
            redirect_q.pc <= recovery_pc;
        end
        if (rst_i) begin
            redirect_q.valid <= 1'b0;
        end else begin
            redirect_q.valid <= enable && resolve.valid && mispredict;   // one-cycle pulse
        end
    end

    assign redirect = redirect_q;

endmodule

// ==== design/branch_predictor.sv ====
// Branch predictor for the fetch stage: counter table plus BTB.
// Lookup is combinational from fetch_pc; resolve trains both tables at the
// next edge. Predicts taken only on a taken counter and a BTB hit.

`timescale 1ns/1ps

module branch_predictor (
    input  logic                clk,
    input  logic                rst_i,
    input  bp_pkg::addr_t       fetch_pc,
    input  bp_pkg::resolve_t    resolve,
    output bp_pkg::prediction_t pred,
    output bp_pkg::redirect_t   redirect,
    output logic                init_done
);
    import bp_pkg::*;

    logic  bht_taken;
    logic  btb_hit;
    addr_t btb_target;
    addr_t fall_through;
    logic  btb_write;

    // bht drops updates itself until the sweep ends
    bht_table u_bht (
        .clk           (clk),
        .rst_i         (rst_i),
        .lookup_pc     (fetch_pc),
        .update_valid  (resolve.valid),
        .update_pc     (resolve.pc),
        .update_taken  (resolve.taken),
        .predict_taken (bht_taken),
        .init_done     (init_done)
    );

    assign btb_write = resolve.valid && resolve.taken && init_done;   // not-taken leaves btb

    btb_table u_btb (
        .clk          (clk),
        .rst_i        (rst_i),
        .lookup_pc    (fetch_pc),
        .write_en     (btb_write),
        .write_pc     (resolve.pc),
        .write_target (resolve.target),
        .hit          (btb_hit),
        .target       (btb_target)
    );

    resolve_unit u_resolve (
        .clk      (clk),
        .rst_i    (rst_i),
        .enable   (init_done),
        .resolve  (resolve),
        .redirect (redirect)
    );

    assign fall_through = fetch_pc + addr_t'(4);

    assign pred.taken   = bht_taken && btb_hit;
    assign pred.next_pc = pred.taken ? btb_target : fall_through;

endmodule

// ==== bench/tb_clk.sv ====
// Clock and reset source for the testbench.
// 4 ns clock period, rst_i held high for the first 5 rising edges.

`timescale 1ns/1ps

module tb_clk (
    output logic clk,
    output logic rst_i
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    initial begin
        rst_i = 1'b1;
        repeat (5) @(posedge clk);
        rst_i <= 1'b0;   // released on the 5th edge
    end

endmodule

// ==== bench/tb_branch_predictor.sv ====
// Testbench for branch_predictor with a reference model of both tables.
// Inputs change just after the rising edge, outputs are compared at the
// falling edge. The model advances at the falling edge with the strobe
// the DUT will sample at the next rising edge.

`timescale 1ns/1ps
`include "bp_settings.svh"

module tb_branch_predictor;
    import bp_pkg::*;

    localparam int unsigned BHT_N           = `BP_BHT_ENTRIES;
    localparam int unsigned BHT_W           = `BP_BHT_IDX_W;
    localparam int unsigned BTB_N           = `BP_BTB_ENTRIES;
    localparam int unsigned BTB_W           = `BP_BTB_IDX_W;
    localparam int unsigned TAG_W           = `BP_BTB_TAG_W;
    localparam int unsigned DIRECTED_CYCLES = 64;
    localparam int unsigned RAND_CYCLES     = 400;
    localparam int unsigned TIMEOUT_CYCLES  = 5 + BHT_N + DIRECTED_CYCLES + RAND_CYCLES + 100;

    localparam addr_t PC_A = 32'h0000_1000;
    localparam addr_t TGT_A = 32'h0000_1800;
    localparam addr_t PC_B = PC_A ^ 32'h0000_0400;   // shares counter and btb index with PC_A
    localparam addr_t PC_C = 32'h0000_2040;
    localparam addr_t TGT_C = 32'h0000_3000;

    logic        clk;
    logic        rst_i;
    addr_t       fetch_pc;
    resolve_t    resolve;
    prediction_t pred;
    redirect_t   redirect;
    logic        init_done;

    // reference model state
    int unsigned      ref_ctr [BHT_N];
    logic             ref_valid [BTB_N];
    logic [TAG_W-1:0] ref_tag [BTB_N];
    addr_t            ref_target [BTB_N];
    int unsigned      ref_cycles;   // edges since rst_i fell up to BHT_N
    logic             ref_done;
    redirect_t        exp_redirect;

    integer      seed;

    tb_clk u_tb_clk (
        .clk   (clk),
        .rst_i (rst_i)
    );

    branch_predictor u_branch_predictor (
        .clk       (clk),
        .rst_i     (rst_i),
        .fetch_pc  (fetch_pc),
        .resolve   (resolve),
        .pred      (pred),
        .redirect  (redirect),
        .init_done (init_done)
    );

    task automatic mismatch(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
        $display("FAILED at %0t: %s expected %h actual %h", $time, name, expected, actual);
        $display("sim failed");
        $fatal(1, "value check failed");
    endtask

    task automatic abort_with(input string what);
        $display("%s at %0t", what, $time);
        $display("sim failed");
        $fatal(1, "check failed");
    endtask

    // what fetch should see for pc from the model tables
    function automatic prediction_t predict_ref(input addr_t pc);
        prediction_t p;
        int unsigned bi;
        int unsigned ti;
        logic        hit;
        bi = int'(pc[BHT_W+1:2]);
        ti = int'(pc[BTB_W+1:2]);
        hit = ref_valid[ti] && (ref_tag[ti] == pc[31 -: TAG_W]);
        p.taken = ref_done && (ref_ctr[bi] >= 2) && hit;   // msb is the direction
        p.next_pc = p.taken ? ref_target[ti] : pc + 32'd4;
        return p;
    endfunction

    function automatic redirect_t expected_redirect(input resolve_t r, input logic done);
        redirect_t e;
        logic      wrong;
        wrong = (r.taken != r.pred_taken) || (r.taken && (r.target != r.pred_target));
        e.valid = done && r.valid && wrong;
        e.pc = r.taken ? r.target : r.pc + 32'd4;
        return e;
    endfunction

    function automatic void train_ref(input resolve_t r);
        int unsigned bi;
        int unsigned ti;
        bi = int'(r.pc[BHT_W+1:2]);
        ti = int'(r.pc[BTB_W+1:2]);
        if (r.taken && ref_ctr[bi] < 3) begin
            ref_ctr[bi] = ref_ctr[bi] + 1;
        end else if (!r.taken && ref_ctr[bi] > 0) begin
            ref_ctr[bi] = ref_ctr[bi] - 1;
        end
        if (r.taken) begin
            ref_valid[ti] = 1'b1;
            ref_tag[ti] = r.pc[31 -: TAG_W];
            ref_target[ti] = r.target;
        end
    endfunction

    // compare at the falling edge and then step the model to the next rising edge
    always @(negedge clk) begin
        prediction_t exp_pred;
        ref_done = !rst_i && (ref_cycles >= BHT_N);
        exp_pred = predict_ref(fetch_pc);
        assert (init_done === ref_done)
            else mismatch("init_done", 64'(ref_done), 64'(init_done));
        assert (redirect.valid === exp_redirect.valid)
            else mismatch("redirect.valid", 64'(exp_redirect.valid), 64'(redirect.valid));
        if (exp_redirect.valid) begin
            assert (redirect.pc === exp_redirect.pc)
                else mismatch("redirect.pc", 64'(exp_redirect.pc), 64'(redirect.pc));
        end
        assert (pred.taken === exp_pred.taken)
            else mismatch("pred.taken", 64'(exp_pred.taken), 64'(pred.taken));
        assert (pred.next_pc === exp_pred.next_pc)
            else mismatch("pred.next_pc", 64'(exp_pred.next_pc), 64'(pred.next_pc));
        if (rst_i) begin
            ref_cycles = 0;
            exp_redirect = '0;
            for (int i = 0; i < BTB_N; i++) begin
                ref_valid[i] = 1'b0;
            end
            for (int i = 0; i < BHT_N; i++) begin
                ref_ctr[i] = `BP_CTR_INIT;
            end
        end else begin
            exp_redirect = expected_redirect(resolve, ref_done);
            if (ref_done && resolve.valid) begin
                train_ref(resolve);
            end
            if (ref_cycles < BHT_N) begin
                ref_cycles = ref_cycles + 1;
            end
        end
    end

    task automatic drive(input addr_t pc, input resolve_t r);
        @(posedge clk);
        fetch_pc <= pc;
        resolve <= r;
    endtask

    function automatic resolve_t make_resolve(input addr_t pc, input logic taken,
                                              input addr_t target, input logic p_taken,
                                              input addr_t p_target);
        resolve_t r;
        r.valid = 1'b1;
        r.pc = pc;
        r.taken = taken;
        r.target = target;
        r.pred_taken = p_taken;
        r.pred_target = p_target;
        return r;
    endfunction

    // carries the prediction fetch got for pc from the current tables
    function automatic resolve_t fetched_resolve(input addr_t pc, input logic taken,
                                                 input addr_t target);
        prediction_t p;
        p = predict_ref(pc);
        return make_resolve(pc, taken, target, p.taken, p.next_pc);
    endfunction

    task automatic check_lookup(input addr_t pc, input logic exp_taken, input addr_t exp_next);
        drive(pc, '0);
        @(negedge clk);
        assert (pred.taken === exp_taken)
            else mismatch("pred.taken", 64'(exp_taken), 64'(pred.taken));
        assert (pred.next_pc === exp_next)
            else mismatch("pred.next_pc", 64'(exp_next), 64'(pred.next_pc));
    endtask

    // send r and look at the redirect left by the strobe before it
    task automatic step_resolve(input resolve_t r, input logic prev_valid, input addr_t prev_pc);
        drive(PC_C, r);
        @(negedge clk);
        assert (redirect.valid === prev_valid)
            else mismatch("redirect.valid", 64'(prev_valid), 64'(redirect.valid));
        if (prev_valid) begin
            assert (redirect.pc === prev_pc)
                else mismatch("redirect.pc", 64'(prev_pc), 64'(redirect.pc));
        end
    endtask

    function automatic addr_t random_pc();
        logic [31:0] rnd;
        rnd = $random(seed);
        // 16 tags over 4 indexes so that entries alias often
        return 32'h0001_0000 | {20'd0, rnd[11:8], 8'd0} | {28'd0, rnd[3:2], 2'd0};
    endfunction

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles with tests still running", TIMEOUT_CYCLES);
        $display("sim failed");
        $fatal(1, "timeout");
    end

    initial begin
        int unsigned waited;
        addr_t       fpc;
        addr_t       rpc;
        addr_t       tgt;
        resolve_t    r;
        logic [31:0] rnd;
        seed = 32'h749a;
        ref_cycles = 0;
        exp_redirect = '0;
        fetch_pc = '0;
        resolve = '0;
        @(negedge rst_i);

        // strobes during the sweep must be dropped
        for (int i = 0; i < 12; i++) begin
            drive(PC_A, make_resolve(PC_A, 1'b1, TGT_A, 1'b0, PC_A + 32'd4));
        end
        waited = 0;
        while (init_done !== 1'b1) begin
            drive(PC_A, '0);
            @(negedge clk);
            waited = waited + 1;
            if (waited > BHT_N + 8) begin
                abort_with("init_done never rose after the reset sweep");
            end
        end
        check_lookup(PC_A, 1'b0, PC_A + 32'd4);

        // training up to strong taken
        drive(PC_A, fetched_resolve(PC_A, 1'b1, TGT_A));
        drive(PC_A, fetched_resolve(PC_A, 1'b1, TGT_A));
        check_lookup(PC_A, 1'b1, TGT_A);

        // hysteresis
        drive(PC_A, fetched_resolve(PC_A, 1'b0, TGT_A));
        check_lookup(PC_A, 1'b1, TGT_A);
        drive(PC_A, fetched_resolve(PC_A, 1'b0, TGT_A));
        check_lookup(PC_A, 1'b0, PC_A + 32'd4);

        // retrain and then alias with a different tag
        drive(PC_A, fetched_resolve(PC_A, 1'b1, TGT_A));
        drive(PC_A, fetched_resolve(PC_A, 1'b1, TGT_A));
        check_lookup(PC_B, 1'b0, PC_B + 32'd4);
        check_lookup(PC_A, 1'b1, TGT_A);

        // back-to-back redirects
        step_resolve(make_resolve(PC_C, 1'b1, TGT_C, 1'b0, PC_C + 32'd4), 1'b0, '0);
        step_resolve(make_resolve(PC_C, 1'b1, TGT_C, 1'b1, TGT_C + 32'd8), 1'b1, TGT_C);
        step_resolve(make_resolve(PC_C, 1'b1, TGT_C, 1'b1, TGT_C), 1'b1, TGT_C);
        step_resolve(make_resolve(PC_C, 1'b0, TGT_C, 1'b1, TGT_C), 1'b0, '0);
        step_resolve(make_resolve(PC_C, 1'b0, TGT_C, 1'b0, PC_C + 32'd4), 1'b1, PC_C + 32'd4);
        step_resolve('0, 1'b0, '0);

        // mixed random traffic checked by the model every cycle
        for (int i = 0; i < RAND_CYCLES; i++) begin
            rnd = $random(seed);
            fpc = random_pc();
            rpc = random_pc();
            tgt = rnd[1] ? rpc + 32'h40 : random_pc() + 32'h8000;
            if (rnd[2]) begin
                r = '0;
            end else if (rnd[4:3] != 2'b00) begin
                r = fetched_resolve(rpc, rnd[5], tgt);
            end else begin
                r = make_resolve(rpc, rnd[5], tgt, rnd[6], rnd[7] ? tgt : tgt + 32'd4);
            end
            drive(fpc, r);
        end
        drive(PC_A, '0);
        repeat (2) @(negedge clk);

        $display("sim passed");
        $finish;
    end

endmodule

// ==== branch_predictor.f ====
+incdir+design
design/bp_pkg.sv
design/bht_table.sv
design/btb_table.sv
design/resolve_unit.sv
design/branch_predictor.sv
bench/tb_clk.sv
bench/tb_branch_predictor.sv

// ==== Bender.yml ====
package:
  name: branch_predictor

sources:
  - include_dirs:
      - design
    files:
      - design/bp_pkg.sv
      - design/bht_table.sv
      - design/btb_table.sv
      - design/resolve_unit.sv
      - design/branch_predictor.sv

  - target: test
    include_dirs:
      - design
    files:
      - bench/tb_clk.sv
      - bench/tb_branch_predictor.sv
